//--- include/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus widths
`define ADDR_SIZE 16
`define DATA_SIZE 32

// address map, word addressed
`define INT_MEM_WORDS 256 // startup ram size, also first sram address
`define EXT_MEM_END 4095 // last external sram word

// uart registers at the top of the map
`define UART_DATA_ADDR 16'hFFF0
`define UART_STATUS_ADDR 16'hFFF1

// serial link
`define CLKS_PER_BIT 16 // clk cycles per serial bit
`define UART_FIFO_DEPTH 4 // entries in each byte queue

`endif

//--- hw/bus_pkg.sv
`include "soc_consts.svh"

package bus_pkg;

	typedef logic [`ADDR_SIZE-1:0] bus_addr_t; // word address
	typedef logic [`DATA_SIZE-1:0] bus_data_t;

	// external sram controller sequence
	// read: set address, get data, finish
	// write: set address, pulse we, finish
	typedef enum logic [2:0] {
		SRAM_WAIT = 3'd0,
		SRAM_RD_SET_ADDR = 3'd1,
		SRAM_RD_DATA_GET = 3'd2,
		SRAM_RD_FINISH = 3'd3,
		SRAM_WR_SET_ADDR = 3'd4,
		SRAM_WR_SET_WE = 3'd5,
		SRAM_WR_FINISH = 3'd6
	} sram_state_t;

endpackage

//--- hw/uart_pkg.sv
`include "soc_consts.svh"

package uart_pkg;

	// one received character
	typedef struct packed {
		logic frame_err; // stop bit sampled low
		logic [7:0] data;
	} rx_frame_t;

	// status word as read from the bus
	typedef struct packed {
		logic [`DATA_SIZE-4:0] reserved; // reads as zero
		logic rx_frame_err; // error flag of head frame
		logic tx_full;
		logic rx_not_empty;
	} uart_status_t;

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic pop,
	input payload_t din,
	output payload_t dout,
	output logic empty,
	output logic full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // entries held
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_push = push && !full; // push on full is dropped
	assign do_pop = pop && !empty; // pop on empty is dropped
	assign dout = mem[rd_ptr]; // head shown ahead of pop

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

//--- hw/startup_ram.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module startup_ram
	import bus_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic read_q,
	input logic write_q,
	input bus_addr_t addr,
	input bus_data_t wdata,
	output bus_data_t rdata,
	output logic read_dn,
	output logic write_dn
);
	localparam int RAM_AW = $clog2(`INT_MEM_WORDS);

	bus_data_t mem [`INT_MEM_WORDS];
	logic hit; // bottom of the map
	logic done_hold; // held request already answered
	logic take; // fresh request for this slave
	logic [RAM_AW-1:0] idx;

	assign hit = (addr < bus_addr_t'(`INT_MEM_WORDS));
	assign idx = addr[RAM_AW-1:0];
	assign take = hit && !done_hold && (read_q || write_q);

	// ram starts cleared
	initial begin
		for (int i = 0; i < `INT_MEM_WORDS; i++)
			mem[i] = '0;
	end

	always @(posedge clk) begin
		if (take && write_q)
			mem[idx] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done_hold <= 1'b0;
			read_dn <= 1'b0;
			write_dn <= 1'b0;
			rdata <= '0;
		end else begin
			read_dn <= 1'b0; // single cycle pulses
			write_dn <= 1'b0;
			rdata <= '0; // zero when idle, shared or bus
			if (!read_q && !write_q)
				done_hold <= 1'b0; // master let go
			else if (take) begin
				done_hold <= 1'b1;
				read_dn <= read_q;
				write_dn <= write_q;
				if (read_q)
					rdata <= mem[idx];
			end
		end
	end

endmodule

//--- hw/sram_ctrl.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module sram_ctrl
	import bus_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic read_q,
	input logic write_q,
	input logic rw_halt,
	input bus_addr_t addr,
	input bus_data_t wdata,
	output bus_data_t rdata,
	output logic read_dn,
	output logic write_dn,
	output bus_addr_t prg_addr,
	inout bus_data_t prg_data,
	output logic prg_ce0,
	output logic prg_oe,
	output logic prg_we
);
	sram_state_t state;
	bus_data_t wr_data; // held on the pins for the whole write
	logic drive_en; // we own prg_data
	logic read_dn_r;
	logic write_dn_r;
	logic done_hold; // request answered, wait for it to drop
	logic hit;

	assign hit = (addr >= bus_addr_t'(`INT_MEM_WORDS)) && (addr <= bus_addr_t'(`EXT_MEM_END));
	assign prg_data = drive_en ? wr_data : 'z;

	// halt in the pulse cycle hides the pulse, the master then retries
	assign read_dn = read_dn_r && !rw_halt;
	assign write_dn = write_dn_r && !rw_halt;

	always_ff @(posedge clk) begin
		if (state == SRAM_WAIT && write_q)
			wr_data <= wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SRAM_WAIT;
			prg_addr <= '0;
			prg_ce0 <= 1'b1;
			prg_oe <= 1'b0;
			prg_we <= 1'b1;
			drive_en <= 1'b0;
			read_dn_r <= 1'b0;
			write_dn_r <= 1'b0;
			rdata <= '0;
			done_hold <= 1'b0;
		end else begin
			read_dn_r <= 1'b0;
			write_dn_r <= 1'b0;
			if ((!read_q && !write_q) || rw_halt)
				done_hold <= 1'b0;
			if (rw_halt) begin
				// drop the access, request stays pending on the bus
				state <= SRAM_WAIT;
				prg_ce0 <= 1'b1;
				prg_oe <= 1'b0;
				prg_we <= 1'b1;
				drive_en <= 1'b0;
				rdata <= '0;
			end else begin
				case (state)
					SRAM_WAIT: begin
						prg_ce0 <= 1'b1; // chip idle
						prg_oe <= 1'b0;
						prg_we <= 1'b1;
						drive_en <= 1'b0;
						rdata <= '0;
						if (hit && !done_hold && (read_q || write_q)) begin
							prg_addr <= addr - bus_addr_t'(`INT_MEM_WORDS); // rebase
							state <= read_q ? SRAM_RD_SET_ADDR : SRAM_WR_SET_ADDR;
						end
					end
					SRAM_RD_SET_ADDR: begin
						prg_ce0 <= 1'b0;
						prg_oe <= 1'b0; // sram drives data
						state <= SRAM_RD_DATA_GET;
					end
					SRAM_RD_DATA_GET: begin
						rdata <= prg_data;
						read_dn_r <= 1'b1;
						done_hold <= 1'b1;
						state <= SRAM_RD_FINISH;
					end
					SRAM_RD_FINISH: begin
						prg_ce0 <= 1'b1;
						rdata <= '0;
						state <= SRAM_WAIT;
					end
					SRAM_WR_SET_ADDR: begin
						prg_ce0 <= 1'b0;
						prg_oe <= 1'b1; // keep the chip off the data pins
						drive_en <= 1'b1;
						state <= SRAM_WR_SET_WE;
					end
					SRAM_WR_SET_WE: begin
						prg_we <= 1'b0;
						state <= SRAM_WR_FINISH;
					end
					SRAM_WR_FINISH: begin
						prg_we <= 1'b1; // sram stores on this rising edge
						write_dn_r <= 1'b1;
						done_hold <= 1'b1;
						state <= SRAM_WAIT;
					end
					default: state <= SRAM_WAIT;
				endcase
			end
		end
	end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module uart_tx (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [7:0] data,
	output logic busy,
	output logic TxD
);
	localparam int CNT_W = $clog2(`CLKS_PER_BIT);

	logic [8:0] shreg; // data bits, stop bit on top
	logic [3:0] bit_cnt; // 0 start, 1..8 data, 9 stop
	logic [CNT_W-1:0] clk_cnt;
	logic bit_end;

	assign bit_end = (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (!busy && start)
			shreg <= {1'b1, data};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[8:1]}; // lsb first
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			TxD <= 1'b1; // line idles high
			bit_cnt <= '0;
			clk_cnt <= '0;
		end else if (!busy) begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			if (start) begin
				busy <= 1'b1;
				TxD <= 1'b0; // start bit
			end
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			if (bit_end) begin
				if (bit_cnt == 4'd9)
					busy <= 1'b0; // stop bit done
				else begin
					TxD <= shreg[0];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module uart_rx
	import uart_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic RxD,
	output rx_frame_t frame,
	output logic valid
);
	localparam int CNT_W = $clog2(`CLKS_PER_BIT);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_s; // synchronised line
	logic rx_prev; // for the falling edge
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic half_bit;
	logic full_bit;

	assign half_bit = (clk_cnt == CNT_W'(`CLKS_PER_BIT / 2 - 1));
	assign full_bit = (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= RxD;
			rx_s <= rx_meta;
			rx_prev <= rx_s;
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && full_bit)
			shreg <= {rx_s, shreg[7:1]}; // lsb arrives first
		if (state == RX_STOP && full_bit)
			frame <= '{frame_err: !rx_s, data: shreg};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (rx_prev && !rx_s)
						state <= RX_START;
				end
				RX_START: if (half_bit) begin
					clk_cnt <= '0; // now centred on the bit
					state <= rx_s ? RX_IDLE : RX_DATA; // glitch, not a start bit
				end
				RX_DATA: if (full_bit) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (full_bit) begin
					valid <= 1'b1; // frame out, good or not
					state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

//--- hw/uart_port.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module uart_port
	import bus_pkg::*;
	import uart_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic read_q,
	input logic write_q,
	input bus_addr_t addr,
	input bus_data_t wdata,
	output bus_data_t rdata,
	output logic read_dn,
	output logic write_dn,
	output logic TxD,
	input logic RxD,
	output logic rx_strobe
);
	logic data_hit;
	logic status_hit;
	logic accept; // fresh request for this slave
	logic done_hold;
	logic tx_push;
	logic tx_pop;
	logic tx_empty;
	logic tx_full;
	logic tx_busy;
	logic [7:0] tx_head;
	logic rx_pop;
	logic rx_empty;
	rx_frame_t rx_frame;
	rx_frame_t rx_head;
	uart_status_t status;

	assign data_hit = (addr == bus_addr_t'(`UART_DATA_ADDR));
	assign status_hit = (addr == bus_addr_t'(`UART_STATUS_ADDR));
	assign accept = (data_hit || status_hit) && !done_hold;

	// data write stalls here while the tx queue is full
	assign tx_push = accept && write_q && data_hit && !tx_full;
	assign rx_pop = accept && read_q && data_hit; // empty pop ignored by fifo
	assign tx_pop = !tx_empty && !tx_busy; // also starts the serialiser

	assign status = '{
		reserved: '0,
		rx_frame_err: !rx_empty && rx_head.frame_err,
		tx_full: tx_full,
		rx_not_empty: !rx_empty
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
			read_dn <= 1'b0;
			write_dn <= 1'b0;
			done_hold <= 1'b0;
		end else begin
			read_dn <= 1'b0;
			write_dn <= 1'b0;
			rdata <= '0; // idle reply is zero
			if (!read_q && !write_q)
				done_hold <= 1'b0;
			else if (accept && read_q) begin
				read_dn <= 1'b1;
				done_hold <= 1'b1;
				if (status_hit)
					rdata <= bus_data_t'(status);
				else if (!rx_empty)
					rdata <= bus_data_t'(rx_head); // error flag lands on bit 8
			end else if (accept && write_q && (status_hit || !tx_full)) begin
				write_dn <= 1'b1; // status is read only, write just acked
				done_hold <= 1'b1;
			end
		end
	end

	sync_fifo #(.payload_t(logic [7:0]), .DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(tx_push),
		.pop(tx_pop),
		.din(wdata[7:0]),
		.dout(tx_head),
		.empty(tx_empty),
		.full(tx_full)
	);

	uart_tx tx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(tx_pop),
		.data(tx_head),
		.busy(tx_busy),
		.TxD(TxD)
	);

	uart_rx rx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.RxD(RxD),
		.frame(rx_frame),
		.valid(rx_strobe)
	);

	sync_fifo #(.payload_t(rx_frame_t), .DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(rx_strobe), // overflow drops the frame
		.pop(rx_pop),
		.din(rx_frame),
		.dout(rx_head),
		.empty(rx_empty),
		.full()
	);

endmodule

//--- hw/soc_top.sv
`timescale 1ns/1ps

module soc_top
	import bus_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic read_q,
	input logic write_q,
	input logic rw_halt,
	input bus_addr_t addr,
	input bus_data_t wdata,
	output bus_data_t rdata,
	output logic read_dn,
	output logic write_dn,
	output bus_addr_t prg_addr,
	inout bus_data_t prg_data,
	output logic prg_ce0,
	output logic prg_oe,
	output logic prg_we,
	output logic TxD,
	input logic RxD,
	output logic rx_strobe
);
	bus_data_t ram_rdata;
	logic ram_read_dn;
	logic ram_write_dn;
	bus_data_t ext_rdata;
	logic ext_read_dn;
	logic ext_write_dn;
	bus_data_t uart_rdata;
	logic uart_read_dn;
	logic uart_write_dn;

	startup_ram ram_inst (
		.clk(clk),
		.rst_n(rst_n),
		.read_q(read_q),
		.write_q(write_q),
		.addr(addr),
		.wdata(wdata),
		.rdata(ram_rdata),
		.read_dn(ram_read_dn),
		.write_dn(ram_write_dn)
	);

	sram_ctrl sram_inst (
		.clk(clk),
		.rst_n(rst_n),
		.read_q(read_q),
		.write_q(write_q),
		.rw_halt(rw_halt),
		.addr(addr),
		.wdata(wdata),
		.rdata(ext_rdata),
		.read_dn(ext_read_dn),
		.write_dn(ext_write_dn),
		.prg_addr(prg_addr),
		.prg_data(prg_data),
		.prg_ce0(prg_ce0),
		.prg_oe(prg_oe),
		.prg_we(prg_we)
	);

	uart_port uart_inst (
		.clk(clk),
		.rst_n(rst_n),
		.read_q(read_q),
		.write_q(write_q),
		.addr(addr),
		.wdata(wdata),
		.rdata(uart_rdata),
		.read_dn(uart_read_dn),
		.write_dn(uart_write_dn),
		.TxD(TxD),
		.RxD(RxD),
		.rx_strobe(rx_strobe)
	);

	// idle slaves return zero, so plain or merges the replies
	assign rdata = ram_rdata | ext_rdata | uart_rdata;
	assign read_dn = ram_read_dn | ext_read_dn | uart_read_dn;
	assign write_dn = ram_write_dn | ext_write_dn | uart_write_dn;

endmodule

//--- bench/soc_checker.sv
`timescale 1ns/1ps

module soc_checker (
	input logic clk,
	input logic rst_n,
	input logic read_q,
	input logic write_q,
	input logic rw_halt,
	input logic read_dn,
	input logic write_dn,
	input logic prg_ce0,
	input logic prg_we
);
	int fail_count = 0; // read by the bench at the end

	// done flags are single cycle pulses
	a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_dn |=> !read_dn)
		else begin fail_count++; $error("read_dn high for more than one cycle"); end
	a_write_pulse: assert property (@(posedge clk) disable iff (!rst_n) write_dn |=> !write_dn)
		else begin fail_count++; $error("write_dn high for more than one cycle"); end
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n) !(read_dn && write_dn))
		else begin fail_count++; $error("read_dn and write_dn high together"); end

	// external chip only written while selected
	a_we_under_ce: assert property (@(posedge clk) disable iff (!rst_n) !prg_we |-> !prg_ce0)
		else begin fail_count++; $error("prg_we low while prg_ce0 high"); end

	// halt swallows every reply
	a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		rw_halt |-> !read_dn && !write_dn)
		else begin fail_count++; $error("done pulse while rw_halt high"); end

	// a pulse needs a request held since the cycle before
	a_read_pending: assert property (@(posedge clk) disable iff (!rst_n)
		read_dn |-> read_q && $past(read_q))
		else begin fail_count++; $error("read_dn without a pending read"); end
	a_write_pending: assert property (@(posedge clk) disable iff (!rst_n)
		write_dn |-> write_q && $past(write_q))
		else begin fail_count++; $error("write_dn without a pending write"); end

endmodule

//--- bench/soc_tb.sv
`timescale 1ns/1ps
`include "soc_consts.svh"

module soc_tb
	import bus_pkg::*;
();
	localparam int EXT_WORDS = `EXT_MEM_END + 1 - `INT_MEM_WORDS;
	localparam int FRAME_CYCLES = 10 * `CLKS_PER_BIT; // start, 8 data, stop
	localparam int REQ_LIMIT = 3 * FRAME_CYCLES; // worst stall is about one frame
	localparam int WATCHDOG_CYCLES = 20 * FRAME_CYCLES + 2000;
	localparam int N_WORDS = 12;
	localparam bus_data_t ST_RX_NOT_EMPTY = 32'h1;
	localparam bus_data_t ST_TX_FULL = 32'h2;

	logic clk;
	logic rst_n;
	logic read_q;
	logic write_q;
	logic rw_halt;
	bus_addr_t addr;
	bus_data_t wdata;
	bus_data_t rdata;
	logic read_dn;
	logic write_dn;
	bus_addr_t prg_addr;
	wire [`DATA_SIZE-1:0] prg_data;
	logic prg_ce0;
	logic prg_oe;
	logic prg_we;
	wire serial_line; // TxD looped to RxD
	logic rx_strobe;

	bus_data_t sram_mem [EXT_WORDS]; // external chip
	bus_data_t ram_shadow [`INT_MEM_WORDS];
	bus_data_t ext_shadow [EXT_WORDS];
	int data_errors = 0;
	int req_errors = 0;
	int watchdog_hits = 0;
	int strobe_count;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	soc_top soc_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.read_q(read_q),
		.write_q(write_q),
		.rw_halt(rw_halt),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.read_dn(read_dn),
		.write_dn(write_dn),
		.prg_addr(prg_addr),
		.prg_data(prg_data),
		.prg_ce0(prg_ce0),
		.prg_oe(prg_oe),
		.prg_we(prg_we),
		.TxD(serial_line),
		.RxD(serial_line),
		.rx_strobe(rx_strobe)
	);

	bind soc_top soc_checker chk_inst (
		.clk(clk),
		.rst_n(rst_n),
		.read_q(read_q),
		.write_q(write_q),
		.rw_halt(rw_halt),
		.read_dn(read_dn),
		.write_dn(write_dn),
		.prg_ce0(prg_ce0),
		.prg_we(prg_we)
	);

	// sram model, drives on read, stores on rising we
	assign prg_data = (!prg_ce0 && !prg_oe && prg_we) ? sram_mem[prg_addr] : 'z;

	always @(posedge prg_we) begin
		if (prg_ce0 === 1'b0)
			sram_mem[prg_addr] <= prg_data;
	end

	initial begin
		for (int i = 0; i < EXT_WORDS; i++)
			sram_mem[i] = (i * 32'h9e3779b9) ^ 32'h5a5a0000; // every address bit matters
	end

	always @(posedge clk) begin
		if (!rst_n)
			strobe_count <= 0;
		else if (rx_strobe)
			strobe_count <= strobe_count + 1;
	end

	task automatic check_word(input string name, input bus_data_t exp, input bus_data_t act);
		assert (act === exp) else begin
			data_errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic bus_write(input bus_addr_t a, input bus_data_t d, input string name,
			output int cycles);
		bit done;
		done = 1'b0;
		cycles = 0;
		@(posedge clk);
		addr <= a;
		wdata <= d;
		write_q <= 1'b1;
		while (!done && cycles < REQ_LIMIT) begin
			@(posedge clk);
			cycles++;
			done = write_dn;
		end
		write_q <= 1'b0; // drop right after the pulse
		if (!done) begin
			req_errors++;
			$display("%s: write to %h never completed", name, a);
		end
	endtask

	task automatic bus_read(input bus_addr_t a, input string name, output bus_data_t data);
		bit done;
		int cycles;
		done = 1'b0;
		cycles = 0;
		data = '0;
		@(posedge clk);
		addr <= a;
		read_q <= 1'b1;
		while (!done && cycles < REQ_LIMIT) begin
			@(posedge clk);
			cycles++;
			done = read_dn;
			data = rdata;
		end
		read_q <= 1'b0;
		if (!done) begin
			req_errors++;
			$display("%s: read of %h never completed", name, a);
		end
	endtask

	// halt hits while the controller sets the address
	task automatic halt_read(input bus_addr_t a, input string name, output bus_data_t data);
		bit done;
		int cycles;
		done = 1'b0;
		cycles = 0;
		data = '0;
		@(posedge clk);
		addr <= a;
		read_q <= 1'b1;
		@(posedge clk);
		rw_halt <= 1'b1;
		repeat (2) @(posedge clk);
		rw_halt <= 1'b0; // request still held, access restarts
		while (!done && cycles < REQ_LIMIT) begin
			@(posedge clk);
			cycles++;
			done = read_dn;
			data = rdata;
		end
		read_q <= 1'b0;
		if (!done) begin
			req_errors++;
			$display("%s: read of %h never completed after halt", name, a);
		end else if (cycles < 3) begin
			req_errors++; // a restarted read needs a fresh sample plus two cycles
			$display("%s: read of %h finished before the halted access restarted",
				name, a);
		end
	endtask

	task automatic wait_frames(input int target, input string name);
		int cycles;
		cycles = 0;
		while (strobe_count < target && cycles < REQ_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (strobe_count < target) begin
			req_errors++;
			$display("%s: frame %0d never arrived on the serial loopback", name, target);
		end
	endtask

	task automatic finish_run();
		int protocol_errors;
		protocol_errors = soc_top_inst.chk_inst.fail_count;
		$display("errors: data %0d, request %0d, protocol %0d, watchdog %0d",
			data_errors, req_errors, protocol_errors, watchdog_hits);
		if (data_errors + req_errors + protocol_errors + watchdog_hits == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		watchdog_hits++;
		$display("watchdog expired before the tests finished");
		finish_run();
	end

	initial begin
		bus_addr_t a;
		bus_addr_t addr_q [$];
		bus_data_t d;
		bus_data_t got;
		logic [7:0] b;
		logic [7:0] tx_bytes [$];
		int lat;
		int base;
		void'($urandom(32'h3aca));
		rst_n <= 1'b0;
		read_q <= 1'b0;
		write_q <= 1'b0;
		rw_halt <= 1'b0;
		addr <= '0;
		wdata <= '0;
		for (int i = 0; i < `INT_MEM_WORDS; i++)
			ram_shadow[i] = '0; // ram comes up cleared
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		assert (!read_dn && !write_dn && prg_ce0 && prg_we && !prg_oe && serial_line) else begin
			data_errors++;
			$display("outputs not at their idle values after reset");
		end

		// startup ram
		repeat (N_WORDS) begin
			a = bus_addr_t'($urandom_range(`INT_MEM_WORDS - 1));
			d = $urandom;
			bus_write(a, d, "ram_write", lat);
			ram_shadow[a] = d;
			addr_q.push_back(a);
		end
		foreach (addr_q[i]) begin
			bus_read(addr_q[i], "ram_read", got);
			check_word("ram_read", ram_shadow[addr_q[i]], got);
		end

		// external sram, rebased by the ram size
		addr_q.delete();
		repeat (N_WORDS) begin
			a = bus_addr_t'($urandom_range(`EXT_MEM_END, `INT_MEM_WORDS));
			d = $urandom;
			bus_write(a, d, "sram_write", lat);
			ext_shadow[a - `INT_MEM_WORDS] = d;
			addr_q.push_back(a);
		end
		foreach (addr_q[i]) begin
			bus_read(addr_q[i], "sram_read", got);
			check_word("sram_read", ext_shadow[addr_q[i] - `INT_MEM_WORDS], got);
			check_word("sram_model", ext_shadow[addr_q[i] - `INT_MEM_WORDS],
				sram_mem[addr_q[i] - `INT_MEM_WORDS]);
		end
		halt_read(addr_q[0], "sram_halt_read", got);
		check_word("sram_halt_read", ext_shadow[addr_q[0] - `INT_MEM_WORDS], got);

		// uart loopback, frames pile up in the rx queue
		base = strobe_count;
		repeat (3) begin
			b = 8'($urandom);
			tx_bytes.push_back(b);
			bus_write(`UART_DATA_ADDR, {24'b0, b}, "uart_write", lat);
		end
		wait_frames(base + 3, "uart_loopback");
		foreach (tx_bytes[i]) begin
			bus_read(`UART_STATUS_ADDR, "uart_status", got);
			check_word("uart_status", ST_RX_NOT_EMPTY, got);
			bus_read(`UART_DATA_ADDR, "uart_data", got);
			check_word("uart_data", {24'b0, tx_bytes[i]}, got); // error flag clear
		end
		bus_read(`UART_STATUS_ADDR, "uart_status_drained", got);
		check_word("uart_status_drained", '0, got);

		// back pressure, one byte in flight plus a full queue
		tx_bytes.delete();
		base = strobe_count;
		repeat (`UART_FIFO_DEPTH + 1) begin
			b = 8'($urandom);
			tx_bytes.push_back(b);
			bus_write(`UART_DATA_ADDR, {24'b0, b}, "uart_fill", lat);
		end
		bus_read(`UART_STATUS_ADDR, "uart_status_full", got);
		check_word("uart_status_full", ST_TX_FULL, got);
		b = 8'($urandom);
		tx_bytes.push_back(b);
		bus_write(`UART_DATA_ADDR, {24'b0, b}, "uart_stall", lat);
		assert (lat > `CLKS_PER_BIT) else begin
			data_errors++;
			$display("write to a full transmit queue finished after %0d cycles", lat);
		end
		foreach (tx_bytes[i]) begin
			wait_frames(base + i + 1, "uart_burst"); // drain as frames land
			bus_read(`UART_DATA_ADDR, "uart_burst_data", got);
			check_word("uart_burst_data", {24'b0, tx_bytes[i]}, got);
		end

		finish_run();
	end

endmodule

//--- project.f
+incdir+include
hw/bus_pkg.sv
hw/uart_pkg.sv
hw/sync_fifo.sv
hw/startup_ram.sv
hw/sram_ctrl.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_port.sv
hw/soc_top.sv
bench/soc_checker.sv
bench/soc_tb.sv
